// ==== Makefile ====
VERILATOR ?= verilator
TOP       := histTopTb
FILELIST  := histTop.f
FLAGS     := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
RUN_OPTS  := +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_OPTS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(BUILD_DIR)

// ==== histTop.f ====
rtl/histPkg.sv
rtl/histRamIf.sv
rtl/histRam.sv
rtl/acqWindow.sv
rtl/binAccumulator.sv
rtl/histReadout.sv
rtl/histTop.sv
tests/histTopChecker.sv
tests/histTopTb.sv

// ==== rtl/acqWindow.sv ====
`timescale 1ns/1ps

module acqWindow #(
    parameter int acqPerFrame = histPkg::defAcqPerFrame
) (
    input  logic clk,
    input  logic res,
    input  logic syncPulse,
    input  logic busy,
    output logic frameEnd
);

    localparam int cntWidth = $clog2(acqPerFrame + 1);
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(acqPerFrame - 1);

    logic [cntWidth-1:0] syncCount; // pulses seen in this frame

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            syncCount <= '0;
            frameEnd <= 1'b0;
        end else begin
            frameEnd <= 1'b0;
            if (syncPulse && !busy) begin // sync during readout is dropped
                if (syncCount == lastCount) begin
                    syncCount <= '0;
                    frameEnd <= 1'b1;
                end else begin
                    syncCount <= syncCount + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/binAccumulator.sv ====
`timescale 1ns/1ps

module binAccumulator #(
    parameter int countWidth = histPkg::defCountWidth
) (
    input  logic clk,
    input  logic res,
    input  logic eventValid,
    input  histPkg::tdcWordT eventWord,
    input  logic coarse,
    input  logic epoch,
    input  logic hold,
    output logic eventReady,
    output logic idle,
    histRamIf.acc ram
);

    localparam int bw = histPkg::binWidth;

    logic accept;
    logic [bw-1:0] binAddr;

    logic s1Valid;              // read stage
    logic [bw-1:0] s1Addr;
    logic s2Valid;              // modify and write stage
    logic [bw-1:0] s2Addr;
    logic fwdValid;             // write done on the last edge
    logic [bw-1:0] fwdAddr;
    logic [countWidth-1:0] fwdCount;

    logic [countWidth-1:0] oldCount;
    logic [countWidth-1:0] newCount;

    assign eventReady = !hold;
    assign accept = eventValid && eventReady;

    // coarse bins are the upper bits, zero extended to the address
    assign binAddr = coarse ? bw'(eventWord.coarse.index) : eventWord.fine;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid;
            fwdValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= binAddr;
        s2Addr <= s1Addr;
        fwdAddr <= s2Addr;
        fwdCount <= newCount;
    end

    // The read for s2 was taken on the same edge as the previous write, so
    // that write is missing from rdData and has to be forwarded. Older
    // writes already landed before the read.
    always_comb begin
        if (fwdValid && fwdAddr == s2Addr) begin
            oldCount = fwdCount;
        end else if (ram.rdData[countWidth] != epoch) begin
            oldCount = '0; // stale entry from an earlier frame
        end else begin
            oldCount = ram.rdData[countWidth-1:0];
        end
    end

    assign newCount = (&oldCount) ? oldCount : oldCount + 1'b1; // saturate

    assign ram.rdEn = s1Valid;
    assign ram.rdAddr = s1Addr;
    assign ram.wrEn = s2Valid;
    assign ram.wrAddr = s2Addr;
    assign ram.wrData = {epoch, newCount};

    assign idle = !s1Valid && !s2Valid;

endmodule

// ==== rtl/histPkg.sv ====
package histPkg;

    // timestamp word width, also the fine bin index width
    localparam int binWidth = 6;

    // low bits dropped when binning coarse
    localparam int coarseShift = 2;

    localparam int defCountWidth = 8;   // bits per bin count
    localparam int defAcqPerFrame = 16; // sync pulses per frame

    typedef struct packed {
        logic [binWidth-coarseShift-1:0] index; // coarse bin
        logic [coarseShift-1:0] fineBits;       // dropped in coarse mode
    } coarseWordT;

    // one timestamp word, read either as a fine bin or as a coarse bin
    typedef union packed {
        logic [binWidth-1:0] fine;
        coarseWordT coarse;
    } tdcWordT;

endpackage

// ==== rtl/histRam.sv ====
`timescale 1ns/1ps

module histRam #(
    parameter int countWidth = histPkg::defCountWidth
) (
    input logic clk,
    histRamIf.mem ram
);

    localparam int depth = 2 ** histPkg::binWidth;

    logic [countWidth:0] mem [depth];

    // the tag starts as 1 while the epoch resets to 0, so every bin reads
    // stale in the first frame and no clear pass over the array is needed
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = {1'b1, {countWidth{1'b0}}};
        end
    end

    always @(posedge clk) begin
        if (ram.wrEn) begin
            mem[ram.wrAddr] <= ram.wrData;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (ram.rdEn) begin
            ram.rdData <= mem[ram.rdAddr];
        end
    end

endmodule

// ==== rtl/histRamIf.sv ====
`timescale 1ns/1ps

interface histRamIf #(
    parameter int countWidth = histPkg::defCountWidth
);

    logic rdEn;
    logic [histPkg::binWidth-1:0] rdAddr;
    logic [countWidth:0] rdData; // epoch tag in msb, count below

    logic wrEn;
    logic [histPkg::binWidth-1:0] wrAddr;
    logic [countWidth:0] wrData; // same layout as rdData

    // accumulator uses both ports
    modport acc (output rdEn, rdAddr, wrEn, wrAddr, wrData, input rdData);

    modport rdo (output rdEn, rdAddr, input rdData); // readout only reads

    modport mem (input rdEn, rdAddr, wrEn, wrAddr, wrData, output rdData);

endinterface

// ==== rtl/histReadout.sv ====
`timescale 1ns/1ps

module histReadout #(
    parameter int countWidth = histPkg::defCountWidth
) (
    input  logic clk,
    input  logic res,
    input  logic start,
    input  logic coarse,
    input  logic epoch,
    input  logic binReady,
    output logic binValid,
    output logic [histPkg::binWidth-1:0] binIndex,
    output logic [countWidth-1:0] binCount,
    output logic [histPkg::binWidth-1:0] peakIndex,
    output logic [countWidth-1:0] peakCount,
    output logic frameDone,
    output logic busy,
    histRamIf.rdo ram
);

    localparam int bw = histPkg::binWidth;
    localparam logic [bw-1:0] fineLast = '1;
    localparam logic [bw-1:0] coarseLast = bw'((1 << (bw - histPkg::coarseShift)) - 1);

    typedef enum logic [1:0] {
        sIdle,
        sRead,  // first read of the scan
        sLoad,  // read data arriving
        sHold   // beat presented, waiting for binReady
    } stateT;

    stateT state;
    logic [bw-1:0] addr;
    logic [bw-1:0] lastAddr;
    logic beat;
    logic lastBeat;

    assign lastAddr = coarse ? coarseLast : fineLast;
    assign beat = (state == sHold) && binReady;
    assign lastBeat = beat && addr == lastAddr;

    // next address is read on the accepting edge, a stall keeps addr
    assign ram.rdEn = (state == sRead) || (beat && !lastBeat);
    assign ram.rdAddr = (state == sRead) ? addr : addr + 1'b1;

    assign binValid = (state == sHold);
    assign binIndex = addr;
    assign busy = (state != sIdle) || frameDone; // covers the frameDone cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sIdle;
            addr <= '0;
            frameDone <= 1'b0;
            peakIndex <= '0;
            peakCount <= '0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                sIdle: begin
                    if (start) begin
                        addr <= '0;
                        peakIndex <= '0;
                        peakCount <= '0;
                        state <= sRead;
                    end
                end
                sRead: state <= sLoad;
                sLoad: state <= sHold;
                sHold: begin
                    if (binReady) begin
                        if (binCount > peakCount) begin // strict, lower index keeps ties
                            peakCount <= binCount;
                            peakIndex <= addr;
                        end
                        if (lastBeat) begin
                            frameDone <= 1'b1;
                            state <= sIdle;
                        end else begin
                            addr <= addr + 1'b1;
                            state <= sLoad;
                        end
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sLoad) begin
            binCount <= (ram.rdData[countWidth] == epoch) ? ram.rdData[countWidth-1:0] : '0;
        end
    end

endmodule

// ==== rtl/histTop.sv ====
`timescale 1ns/1ps

module histTop #(
    parameter int countWidth = histPkg::defCountWidth,
    parameter int acqPerFrame = histPkg::defAcqPerFrame
) (
    input  logic clk,
    input  logic res,
    input  logic eventValid,
    input  logic [histPkg::binWidth-1:0] eventWord,
    input  logic coarseMode,
    input  logic syncPulse,
    input  logic binReady,
    output logic eventReady,
    output logic binValid,
    output logic [histPkg::binWidth-1:0] binIndex,
    output logic [countWidth-1:0] binCount,
    output logic [histPkg::binWidth-1:0] peakIndex,
    output logic [countWidth-1:0] peakCount,
    output logic frameDone
);

    logic epoch;         // tag written with every count
    logic coarseLatched; // mode of the running frame
    logic pending;       // frame ended, waiting for the pipeline to drain
    logic frameEnd;
    logic accIdle;
    logic rdoBusy;
    logic rdoStart;
    logic hold;

    histRamIf #(.countWidth(countWidth)) accIf ();
    histRamIf #(.countWidth(countWidth)) rdoIf ();
    histRamIf #(.countWidth(countWidth)) ramIf ();

    assign hold = pending || rdoBusy;
    assign rdoStart = pending && accIdle;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            epoch <= 1'b0;
            coarseLatched <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (frameEnd) begin
                pending <= 1'b1;
            end else if (rdoStart) begin
                pending <= 1'b0;
            end
            if (frameDone) begin // histogram is out, open the next frame
                epoch <= ~epoch;
                coarseLatched <= coarseMode;
            end
        end
    end

    // the accumulator is idle for the whole readout, so the read port
    // only ever has one user
    assign ramIf.rdEn = rdoBusy ? rdoIf.rdEn : accIf.rdEn;
    assign ramIf.rdAddr = rdoBusy ? rdoIf.rdAddr : accIf.rdAddr;

    // each bin is emptied as it is read out, with the ending frame's tag,
    // so a bin hit two frames back cannot reappear under the same epoch
    assign ramIf.wrEn = rdoBusy ? rdoIf.rdEn : accIf.wrEn;
    assign ramIf.wrAddr = rdoBusy ? rdoIf.rdAddr : accIf.wrAddr;
    assign ramIf.wrData = rdoBusy ? {epoch, {countWidth{1'b0}}} : accIf.wrData;
    assign accIf.rdData = ramIf.rdData;
    assign rdoIf.rdData = ramIf.rdData;

    histRam #(.countWidth(countWidth)) u_ram (
        .clk (clk),
        .ram (ramIf.mem)
    );

    acqWindow #(.acqPerFrame(acqPerFrame)) u_window (
        .clk       (clk),
        .res       (res),
        .syncPulse (syncPulse),
        .busy      (hold),
        .frameEnd  (frameEnd)
    );

    binAccumulator #(.countWidth(countWidth)) u_acc (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .eventWord  (eventWord),
        .coarse     (coarseLatched),
        .epoch      (epoch),
        .hold       (hold),
        .eventReady (eventReady),
        .idle       (accIdle),
        .ram        (accIf.acc)
    );

    histReadout #(.countWidth(countWidth)) u_readout (
        .clk       (clk),
        .res       (res),
        .start     (rdoStart),
        .coarse    (coarseLatched),
        .epoch     (epoch),
        .binReady  (binReady),
        .binValid  (binValid),
        .binIndex  (binIndex),
        .binCount  (binCount),
        .peakIndex (peakIndex),
        .peakCount (peakCount),
        .frameDone (frameDone),
        .busy      (rdoBusy),
        .ram       (rdoIf.rdo)
    );

endmodule

// ==== tests/histTopChecker.sv ====
`timescale 1ns/1ps

module histTopChecker #(
    parameter int countWidth = histPkg::defCountWidth
) (
    input logic clk,
    input logic res,
    input logic eventReady,
    input logic binValid,
    input logic binReady,
    input logic [histPkg::binWidth-1:0] binIndex,
    input logic [countWidth-1:0] binCount,
    input logic frameEnd,
    input logic frameDone
);

    int failCount = 0; // assertion failures so far
    logic inReadout;   // from frameEnd up to frameDone

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inReadout <= 1'b0;
        end else if (frameEnd) begin
            inReadout <= 1'b1;
        end else if (frameDone) begin
            inReadout <= 1'b0;
        end
    end

    beatHeld: assert property (@(posedge clk) disable iff (!res)
        binValid && !binReady |=> binValid && $stable(binIndex) && $stable(binCount))
    else begin
        failCount++;
        $error("bin beat dropped or changed before binReady");
    end

    eventsBlocked: assert property (@(posedge clk) disable iff (!res)
        inReadout |-> !eventReady)
    else begin
        failCount++;
        $error("eventReady high between frameEnd and frameDone");
    end

    donePulse: assert property (@(posedge clk) disable iff (!res)
        frameDone |=> !frameDone)
    else begin
        failCount++;
        $error("frameDone longer than one cycle");
    end

endmodule

bind histTop histTopChecker #(.countWidth(countWidth)) u_checker (
    .clk        (clk),
    .res        (res),
    .eventReady (eventReady),
    .binValid   (binValid),
    .binReady   (binReady),
    .binIndex   (binIndex),
    .binCount   (binCount),
    .frameEnd   (frameEnd),
    .frameDone  (frameDone)
);

// ==== tests/histTopTb.sv ====
`timescale 1ns/1ps

module histTopTb;

    localparam int countWidth = 4;
    localparam int acqPerFrame = 16;
    localparam int maxCount = (1 << countWidth) - 1;
    localparam int numRows = 5;
    localparam int numEvents = 21;

    typedef struct packed {
        logic [histPkg::binWidth-1:0] word;
        logic [7:0] rep;                      // copies sent back to back
    } eventT;

    typedef struct packed {
        logic coarse;
        logic [histPkg::binWidth-1:0] carry;  // offered during readout, counts next frame
        logic [7:0] first;                    // first entry in the event table
        logic [7:0] count;
    } frameT;

    string rowName [numRows] = '{
        "fineScatter", "coarseMerge", "epochClear", "saturate", "coarseSaturate"
    };

    eventT events [numEvents] = '{
        '{6'd0, 8'd1}, '{6'd5, 8'd3}, '{6'd63, 8'd1}, '{6'd17, 8'd4},
        '{6'd5, 8'd2}, '{6'd18, 8'd1}, '{6'd40, 8'd2}, '{6'd5, 8'd1},
        '{6'd8, 8'd2}, '{6'd9, 8'd1}, '{6'd10, 8'd1}, '{6'd11, 8'd3},  // all coarse bin 2
        '{6'd52, 8'd2}, '{6'd55, 8'd5},                                 // bin 13 ties bin 2
        '{6'd2, 8'd1}, '{6'd3, 8'd1},
        '{6'd12, 8'd20}, '{6'd30, 8'd15}, '{6'd31, 8'd3},
        '{6'd0, 8'd9}, '{6'd3, 8'd9}
    };

    // the first row has to be fine, the mode latch resets to fine
    frameT frames [numRows] = '{
        '{1'b0, 6'd33, 8'd0, 8'd8},
        '{1'b1, 6'd62, 8'd8, 8'd6},
        '{1'b0, 6'd7, 8'd14, 8'd2},
        '{1'b0, 6'd44, 8'd16, 8'd3},
        '{1'b1, 6'd0, 8'd19, 8'd2}
    };

    logic clk;
    logic res;
    logic eventValid;
    logic [histPkg::binWidth-1:0] eventWord;
    logic coarseMode;
    logic syncPulse;
    logic binReady;
    logic eventReady;
    logic binValid;
    logic [histPkg::binWidth-1:0] binIndex;
    logic [countWidth-1:0] binCount;
    logic [histPkg::binWidth-1:0] peakIndex;
    logic [countWidth-1:0] peakCount;
    logic frameDone;

    int expHist [64];
    int expPeakIndex;
    int expPeakCount;
    int checkCount;
    int errorCount;
    bit carryOffered; // a word is still waiting from the last readout

    histTop #(.countWidth(countWidth), .acqPerFrame(acqPerFrame)) u_dut (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .eventWord  (eventWord),
        .coarseMode (coarseMode),
        .syncPulse  (syncPulse),
        .binReady   (binReady),
        .eventReady (eventReady),
        .binValid   (binValid),
        .binIndex   (binIndex),
        .binCount   (binCount),
        .peakIndex  (peakIndex),
        .peakCount  (peakCount),
        .frameDone  (frameDone)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("Error: %s expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic int binsPerFrame(input logic coarse);
        return coarse ? 16 : 64;
    endfunction

    // coarse bins drop the two low bits of the word
    function automatic int binOf(input logic [histPkg::binWidth-1:0] word, input logic coarse);
        if (coarse) begin
            return int'(word >> 2);
        end
        return int'(word);
    endfunction

    task automatic addHit(input int b);
        if (expHist[b] < maxCount) begin
            expHist[b]++;
        end
    endtask

    task automatic buildExpected(input int r);
        int first;
        first = int'(frames[r].first);
        foreach (expHist[b]) expHist[b] = 0;
        if (r > 0) begin
            addHit(binOf(frames[r-1].carry, frames[r].coarse));
        end
        for (int i = first; i < first + int'(frames[r].count); i++) begin
            for (int k = 0; k < int'(events[i].rep); k++) begin
                addHit(binOf(events[i].word, frames[r].coarse));
            end
        end
        expPeakIndex = 0;
        expPeakCount = 0;
        for (int b = 0; b < binsPerFrame(frames[r].coarse); b++) begin
            if (expHist[b] > expPeakCount) begin // first maximum wins
                expPeakIndex = b;
                expPeakCount = expHist[b];
            end
        end
    endtask

    // called at a falling edge with eventValid already high
    task automatic waitAccept();
        while (!eventReady) @(negedge clk);
        @(negedge clk); // transfer happened on the rising edge in between
        eventValid = 1'b0;
    endtask

    task automatic sendEvents(input int r);
        int first;
        first = int'(frames[r].first);
        if (carryOffered) begin
            waitAccept();
            carryOffered = 1'b0;
        end
        for (int i = first; i < first + int'(frames[r].count); i++) begin
            for (int k = 0; k < int'(events[i].rep); k++) begin
                eventValid = 1'b1;
                eventWord = events[i].word;
                waitAccept();
            end
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
    endtask

    task automatic issueSyncs();
        while (!eventReady) @(negedge clk); // pulses during readout are dropped
        repeat (acqPerFrame) begin
            syncPulse = 1'b1;
            @(negedge clk);
            syncPulse = 1'b0;
            repeat ($urandom_range(1, 3)) @(negedge clk);
        end
    endtask

    task automatic collectBins(input int r);
        int got;
        int nBins;
        bit doneSeen;
        string name;
        got = 0;
        doneSeen = 1'b0;
        name = rowName[r];
        nBins = binsPerFrame(frames[r].coarse);
        coarseMode = (r + 1 < numRows) ? frames[r+1].coarse : 1'b0; // taken at frameDone
        while (!doneSeen) begin
            @(negedge clk);
            if (carryOffered) begin
                checkValue($sformatf("%s eventReady in readout", name), 0, int'(eventReady));
            end
            if (frameDone) begin
                doneSeen = 1'b1;
                checkValue($sformatf("%s peakIndex", name), expPeakIndex, int'(peakIndex));
                checkValue($sformatf("%s peakCount", name), expPeakCount, int'(peakCount));
                checkValue($sformatf("%s bins streamed", name), nBins, got);
            end else begin
                binReady = ($urandom_range(0, 3) != 0); // stall one beat in four
                if (binValid && !carryOffered && r + 1 < numRows) begin
                    carryOffered = 1'b1;
                    eventValid = 1'b1;
                    eventWord = frames[r].carry;
                end
                if (binValid && binReady) begin
                    if (got < nBins) begin
                        checkValue($sformatf("%s index", name), got, int'(binIndex));
                        checkValue($sformatf("%s bin %0d", name, got), expHist[got],
                                   int'(binCount));
                    end
                    got++;
                end
            end
        end
        binReady = 1'b0;
    endtask

    initial begin
        int totalEvents;
        int totalBins;
        int limitCycles;
        clk = 1'b0;
        res = 1'b0;
        eventValid = 1'b0;
        eventWord = '0;
        coarseMode = frames[0].coarse;
        syncPulse = 1'b0;
        binReady = 1'b0;
        checkCount = 0;
        errorCount = 0;
        carryOffered = 1'b0;
        void'($urandom(32'h7d99_5940));

        totalEvents = numRows - 1; // carried words
        totalBins = 0;
        foreach (events[i]) totalEvents += int'(events[i].rep);
        foreach (frames[r]) totalBins += binsPerFrame(frames[r].coarse);
        limitCycles = 20 + 4 * totalEvents + numRows * (4 * acqPerFrame + 20) + 10 * totalBins;

        fork
            begin
                repeat (limitCycles) @(posedge clk);
                $display("Timeout: the run did not finish within %0d cycles", limitCycles);
                $display("Checks: %0d, errors: %0d", checkCount, errorCount);
                $display("Result: FAILED");
                $finish;
            end
        join_none

        repeat (5) @(negedge clk);
        res = 1'b1;

        for (int r = 0; r < numRows; r++) begin
            buildExpected(r);
            sendEvents(r);
            issueSyncs();
            collectBins(r);
        end

        checkValue("assertion failures", 0, u_dut.u_checker.failCount);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
